//--- Makefile
# Verilator build and run of the multiply unit testbench

TOP := mul_unit_tb

.PHONY: sim clean

# The run passes only when the log holds the pass line
sim:
	verilator --binary --timing --assert -j 0 -f mul_unit.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    // The clock runs freely and first rises half a period in
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset is released on a rising edge, as the DUT samples it synchronously
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule : clock_gen

`default_nettype wire

//--- bench/mul_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb import mul_pkg::*; ();

    localparam int NUM_OPS        = 2000;
    localparam int NUM_DIRECTED   = 4;
    localparam int TIMEOUT_CYCLES = 4 * NUM_OPS + 200;

    // One expected result and the enabled edge after which it must show
    typedef struct packed {
        int         due;
        data_word_t value;
    } expect_t;

    logic     clk;
    logic     rst_n;
    logic     clk_en;
    mul_req_t req;
    mul_rsp_t rsp;

    integer   seed;
    int       core_stages;
    int       cycles;
    int       en_count;
    int       n_acc;
    int       burst_left;
    int       drain_cnt;
    logic     prev_en;
    mul_rsp_t last_rsp;
    expect_t  exp_q [$];
    expect_t  head;
    mul_req_t next_req;

    clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (5)
    ) u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mul_unit u_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .clk_en_i (clk_en),
        .req_i    (req),
        .rsp_o    (rsp)
    );

    // ----------------------------------------------------------
    // Reference model and helpers
    // ----------------------------------------------------------

    // Full 64-bit product of the operands read with RV32M signedness
    function automatic data_word_t model_result(mul_op_t op, data_word_t a, data_word_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] full;
        ea = (op != MULHU) ? {{32{a[31]}}, a} : {32'h0, a};
        eb = (op == MUL || op == MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        full = ea * eb;
        if (op == MUL) begin
            return full[31:0];
        end
        return full[63:32];
    endfunction

    function automatic data_word_t corner_word(int unsigned idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'h7fff_ffff;
            3:       return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // Sign corner cases that are issued before the random traffic
    function automatic mul_req_t directed_req(int idx);
        mul_req_t r;
        case (idx)
            0:       r = '{1'b1, MULH, 32'h8000_0000, 32'h8000_0000};
            1:       r = '{1'b1, MULHSU, 32'hffff_fff0, 32'hffff_ffff};
            2:       r = '{1'b1, MULHSU, 32'h8000_0000, 32'hffff_ffff};
            default: r = '{1'b1, MUL, 32'hffff_ffff, 32'hffff_ffff};
        endcase
        return r;
    endfunction

    // A quarter of the operands come from the corner list
    task automatic draw_operand(output data_word_t value);
        int unsigned pick;
        pick = {$random(seed)} % 4;
        if (pick == 0) begin
            value = corner_word({$random(seed)} % 5);
        end else begin
            value = $random(seed);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("test failed");
        $display("%s", msg);
        $fatal(1);
    endtask

    // ----------------------------------------------------------
    // Stimulus, scoreboard and timeout
    // ----------------------------------------------------------

    initial begin
        seed        = 32'hc5ad23dd;
        core_stages = u_dut.CORE_STAGES;
        req         = '0;
        clk_en      = 1'b1;
        cycles      = 0;
        en_count    = 0;
        n_acc       = 0;
        burst_left  = 0;
        drain_cnt   = 0;
        prev_en     = 1'b1;
        last_rsp    = '0;

        while (drain_cnt <= core_stages + 4) begin
            @(posedge clk);
            cycles++;
            assert (cycles <= TIMEOUT_CYCLES)
            else report_failure($sformatf(
                "timeout after %0d cycles, only %0d of %0d results arrived",
                cycles, n_acc - exp_q.size(), NUM_OPS));

            if (rst_n) begin
                // Everything read here is the settled state from before this edge
                if (prev_en) begin
                    if (exp_q.size() > 0 && exp_q[0].due == en_count) begin
                        head = exp_q.pop_front();
                        assert (rsp.valid === 1'b1)
                        else report_failure($sformatf(
                            "mismatch rsp_o.valid expected 0x1 actual 0x%0h",
                            rsp.valid));
                        assert (rsp.product === head.value)
                        else report_failure($sformatf(
                            "mismatch rsp_o.product expected 0x%08h actual 0x%08h",
                            head.value, rsp.product));
                    end else begin
                        assert (rsp.valid === 1'b0)
                        else report_failure($sformatf(
                            "mismatch rsp_o.valid expected 0x0 actual 0x%0h",
                            rsp.valid));
                    end
                end else begin
                    // A frozen edge must leave the response untouched
                    assert (rsp === last_rsp)
                    else report_failure($sformatf(
                        "mismatch rsp_o held expected 0x%09h actual 0x%09h",
                        last_rsp, rsp));
                end
                last_rsp = rsp;

                // Accept bookkeeping uses the inputs the DUT sees on this edge
                if (clk_en) begin
                    en_count++;
                    if (req.valid) begin
                        head.due   = en_count + core_stages + 1;
                        head.value = model_result(req.op, req.multiplicand, req.multiplier);
                        exp_q.push_back(head);
                        n_acc++;
                    end
                end
                prev_en = clk_en;

                // Enabled edges since the last operation went in
                if (n_acc == NUM_OPS && clk_en) begin
                    drain_cnt++;
                end

                // Freeze bursts last 1 to 3 cycles and cover roughly 15% of the time
                if (burst_left > 0) begin
                    clk_en <= 1'b0;
                    burst_left--;
                end else if (({$random(seed)} % 100) < 9) begin
                    clk_en     <= 1'b0;
                    burst_left = {$random(seed)} % 3;
                end else begin
                    clk_en <= 1'b1;
                end

                next_req.op = mul_op_t'($random(seed));
                draw_operand(next_req.multiplicand);
                draw_operand(next_req.multiplier);
                next_req.valid = (n_acc < NUM_OPS) && (({$random(seed)} % 100) < 80);
                if (next_req.valid && n_acc < NUM_DIRECTED) begin
                    next_req = directed_req(n_acc);
                end
                req <= next_req;
            end
        end

        if (n_acc == NUM_OPS && exp_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d results were lost or never issued", exp_q.size()));
        end
    end

endmodule : mul_unit_tb

`default_nettype wire

//--- mul_unit.f
verilog/mul_pkg.sv
verilog/mul_operand_stage.sv
verilog/pipelined_array_multiplier.sv
verilog/mul_result_stage.sv
verilog/mul_unit.sv
bench/clock_gen.sv
bench/mul_unit_tb.sv

//--- verilog/mul_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mul_operand_stage import mul_pkg::*; (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       clk_en_i,
    input  wire mul_req_t   req_i,
    output      data_word_t multiplicand_o,
    output      data_word_t multiplier_o,
    output      logic       valid_o,
    output      mul_tag_t   tag_o
);

    // ----------------------------------------------------------
    // Sign handling
    // ----------------------------------------------------------

    // The multiplicand is rs1 and is signed unless the op is MULHU
    logic mcand_signed;
    // The multiplier is rs2 and is signed only for MUL and MULH
    logic mplier_signed;
    logic mcand_neg;
    logic mplier_neg;
    logic negate;

    data_word_t mcand_mag;
    data_word_t mplier_mag;

    assign mcand_signed  = (req_i.op != MULHU);
    assign mplier_signed = (req_i.op == MUL) || (req_i.op == MULH);

    // An operand only counts as negative when it is read as signed
    assign mcand_neg  = req_i.multiplicand[XLEN-1] & mcand_signed;
    assign mplier_neg = req_i.multiplier[XLEN-1] & mplier_signed;

    // The product is negative when exactly one factor is negative,
    // so MULHSU with a large unsigned multiplier is not flipped
    assign negate = mcand_neg ^ mplier_neg;

    always_comb begin
        // Negative signed operands become their two's-complement magnitude
        mcand_mag  = req_i.multiplicand;
        mplier_mag = req_i.multiplier;
        if (mcand_neg) begin
            mcand_mag = -req_i.multiplicand;
        end
        if (mplier_neg) begin
            mplier_mag = -req_i.multiplier;
        end
    end

    // ----------------------------------------------------------
    // Stage register
    // ----------------------------------------------------------

    // The payload register holds whenever the pipeline is frozen
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            multiplicand_o <= mcand_mag;
            multiplier_o   <= mplier_mag;
            tag_o.op       <= req_i.op;
            tag_o.negate   <= negate;
        end
    end

    // Valid bit of the stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (clk_en_i) begin
            valid_o <= req_i.valid;
        end
    end

endmodule : mul_operand_stage

`default_nettype wire

//--- verilog/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // ----------------------------------------------------------
    // Data width and word type
    // ----------------------------------------------------------

    // Width of one operand and of one returned result word
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_word_t;

    // ----------------------------------------------------------
    // Multiply operations of the RV32M extension
    // ----------------------------------------------------------

    // MUL keeps the low word, the three others keep the high word
    // and differ only in how the operands are interpreted
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_t;

    // Request bundle presented to the unit by the execute stage
    typedef struct packed {
        logic       valid;
        mul_op_t    op;
        data_word_t multiplicand;
        data_word_t multiplier;
    } mul_req_t;

    // Sideband that follows the operands through the unsigned core
    typedef struct packed {
        mul_op_t op;
        logic    negate;
    } mul_tag_t;

    // Result bundle returned to the execute stage
    typedef struct packed {
        logic       valid;
        data_word_t product;
    } mul_rsp_t;

endpackage : mul_pkg

`default_nettype wire

//--- verilog/mul_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mul_result_stage import mul_pkg::*; #(
    parameter int CORE_STAGES = 4
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              clk_en_i,
    input  wire mul_tag_t          tag_i,
    input  wire logic [2*XLEN-1:0] product_i,
    input  wire logic              valid_i,
    output      mul_rsp_t          rsp_o
);

    localparam int PROD_W = 2 * XLEN;

    // ----------------------------------------------------------
    // Tag delay line
    // ----------------------------------------------------------

    // Same depth as the core, so the last entry belongs to the
    // product that the core presents in this cycle
    mul_tag_t tag_pipe [CORE_STAGES];

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            tag_pipe[0] <= tag_i;
            for (int i = 1; i < CORE_STAGES; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    // ----------------------------------------------------------
    // Final register
    // ----------------------------------------------------------

    logic [PROD_W-1:0] product_q;
    mul_tag_t          tag_q;
    logic              valid_q;

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            product_q <= product_i;
            tag_q     <= tag_pipe[CORE_STAGES-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (clk_en_i) begin
            valid_q <= valid_i;
        end
    end

    // ----------------------------------------------------------
    // Sign restore and half select
    // ----------------------------------------------------------

    logic [PROD_W-1:0] signed_product;

    // The core only sees magnitudes, so a negative result is
    // rebuilt here over the full 64 bits before a half is taken
    assign signed_product = tag_q.negate ? -product_q : product_q;

    always_comb begin
        rsp_o.valid = valid_q;
        if (tag_q.op == MUL) begin
            rsp_o.product = signed_product[XLEN-1:0];
        end else begin
            // MULH, MULHSU and MULHU all return the upper word
            rsp_o.product = signed_product[PROD_W-1:XLEN];
        end
    end

endmodule : mul_result_stage

`default_nettype wire

//--- verilog/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit import mul_pkg::*; #(
    // Register stages inside the array multiplier, from 1 to 8
    parameter int CORE_STAGES = 4
) (
    input  wire logic     clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     clk_en_i,
    input  wire mul_req_t req_i,
    output      mul_rsp_t rsp_o
);

    // ----------------------------------------------------------
    // Internal connections
    // ----------------------------------------------------------

    // Magnitude operands and sideband from the first stage
    data_word_t        opnd_mcand;
    data_word_t        opnd_mplier;
    logic              opnd_valid;
    mul_tag_t          opnd_tag;

    // Unsigned product leaving the core
    logic [2*XLEN-1:0] core_product;
    logic              core_valid;

    // ----------------------------------------------------------
    // Operand stage
    // ----------------------------------------------------------

    mul_operand_stage u_operand (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .req_i          (req_i),
        .multiplicand_o (opnd_mcand),
        .multiplier_o   (opnd_mplier),
        .valid_o        (opnd_valid),
        .tag_o          (opnd_tag)
    );

    // ----------------------------------------------------------
    // Multiplier core
    // ----------------------------------------------------------

    // Latency through here is exactly CORE_STAGES enabled cycles
    pipelined_array_multiplier #(
        .CORE_STAGES (CORE_STAGES)
    ) u_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .clk_en_i       (clk_en_i),
        .valid_i        (opnd_valid),
        .multiplicand_i (opnd_mcand),
        .multiplier_i   (opnd_mplier),
        .product_o      (core_product),
        .valid_o        (core_valid)
    );

    // ----------------------------------------------------------
    // Result stage
    // ----------------------------------------------------------

    // The tag skips the core and is delayed by the same depth
    mul_result_stage #(
        .CORE_STAGES (CORE_STAGES)
    ) u_result (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .clk_en_i  (clk_en_i),
        .tag_i     (opnd_tag),
        .product_i (core_product),
        .valid_i   (core_valid),
        .rsp_o     (rsp_o)
    );

endmodule : mul_unit

`default_nettype wire

//--- verilog/pipelined_array_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module pipelined_array_multiplier import mul_pkg::*; #(
    parameter int CORE_STAGES = 4
) (
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              clk_en_i,
    input  wire logic              valid_i,
    input  wire data_word_t        multiplicand_i,
    input  wire data_word_t        multiplier_i,
    output      logic [2*XLEN-1:0] product_o,
    output      logic              valid_o
);

    localparam int PROD_W = 2 * XLEN;

    // ----------------------------------------------------------
    // Pipeline storage
    // ----------------------------------------------------------

    // Running sum and valid bit at the output of every stage
    logic [PROD_W-1:0] sum_q   [CORE_STAGES];
    logic              valid_q [CORE_STAGES];

    // Operands seen by each stage; entry 0 comes straight from the
    // ports, the later ones are registered copies that travel along
    data_word_t mcand_p  [CORE_STAGES];
    data_word_t mplier_p [CORE_STAGES];

    assign mcand_p[0]  = multiplicand_i;
    assign mplier_p[0] = multiplier_i;

    // ----------------------------------------------------------
    // Stages
    // ----------------------------------------------------------

    for (genvar s = 0; s < CORE_STAGES; s++) begin : g_stage

        // Rows handled here; the split spreads the 32 multiplier bits
        // so that no two stages differ by more than one row
        localparam int ROW_LO = (s * XLEN) / CORE_STAGES;
        localparam int ROW_HI = ((s + 1) * XLEN) / CORE_STAGES - 1;

        logic [PROD_W-1:0] sum_base;
        logic              valid_base;
        logic [PROD_W-1:0] acc;

        // The first stage starts from zero, the others from the
        // sum left by the stage before
        if (s == 0) begin : g_first
            assign sum_base   = '0;
            assign valid_base = valid_i;
        end else begin : g_next
            assign sum_base   = sum_q[s-1];
            assign valid_base = valid_q[s-1];
        end

        // Each set multiplier bit adds one shifted copy of the
        // multiplicand to the running sum
        always_comb begin
            acc = sum_base;
            for (int r = ROW_LO; r <= ROW_HI; r++) begin
                if (mplier_p[s][r]) begin
                    acc = acc + (PROD_W'(mcand_p[s]) << r);
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (clk_en_i) begin
                sum_q[s] <= acc;
            end
        end

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                valid_q[s] <= 1'b0;
            end else if (clk_en_i) begin
                valid_q[s] <= valid_base;
            end
        end

        // Operands are only needed by the stages that still have rows
        // left to add, so the last stage does not forward them
        if (s < CORE_STAGES - 1) begin : g_fwd
            always_ff @(posedge clk_i) begin
                if (clk_en_i) begin
                    mcand_p[s+1]  <= mcand_p[s];
                    mplier_p[s+1] <= mplier_p[s];
                end
            end
        end

    end : g_stage

    // ----------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------

    // After the last stage every row has been added in
    assign product_o = sum_q[CORE_STAGES-1];
    assign valid_o   = valid_q[CORE_STAGES-1];

endmodule : pipelined_array_multiplier

`default_nettype wire
